// File: led_board_pkg.sv
// shared widths, register map, response codes and fsm states for the led board block; import where needed
`default_nettype none

package led_board_pkg;

  // --------------------------------------------------------------------------
  // bus widths
  // --------------------------------------------------------------------------

  // axi4-lite address, word addressed registers
  localparam int addr_width = 7;
  // data bus and register width
  localparam int data_width = 32;
  // one strobe per byte lane
  localparam int strb_width = data_width / 8;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [strb_width-1:0] strb_t;

  // --------------------------------------------------------------------------
  // register map and responses
  // --------------------------------------------------------------------------

  // led control rw, blink counter ro
  typedef enum addr_t {
    REG_LED_CTRL    = 'h00,
    REG_BLINK_COUNT = 'h04
  } reg_addr_t;

  // only okay and slverr are ever returned
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

  // write channel: wait for aw+w, then hold b
  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } wr_state_t;

  // read channel: wait for ar, then hold r
  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_t;

  // --------------------------------------------------------------------------
  // timing defaults for a 125 MHz board clock
  // --------------------------------------------------------------------------

  // half a second
  localparam int default_blink_half_period = 62_500_000;
  // 10 ms of stable button level
  localparam int default_debounce_cycles   = 1_250_000;

endpackage

`default_nettype wire

// File: axi_lite_regs.sv
// axi4-lite register slave with the led control register and blink counter status; sits under the top
`default_nettype none

module axi_lite_regs (
  input  wire                        clk,
  input  wire                        rst_n,

  // --------------------------------------------------------------------------
  // axi4-lite slave port
  // --------------------------------------------------------------------------

  // write address channel
  input  wire  led_board_pkg::addr_t awaddr,
  input  wire                        awvalid,
  output logic                       awready,

  // write data channel
  input  wire  led_board_pkg::data_t wdata,
  input  wire  led_board_pkg::strb_t wstrb,
  input  wire                        wvalid,
  output logic                       wready,

  // write response channel
  output led_board_pkg::axi_resp_t   bresp,
  output logic                       bvalid,
  input  wire                        bready,

  // read address channel
  input  wire  led_board_pkg::addr_t araddr,
  input  wire                        arvalid,
  output logic                       arready,

  // read data channel
  output led_board_pkg::data_t       rdata,
  output led_board_pkg::axi_resp_t   rresp,
  output logic                       rvalid,
  input  wire                        rready,

  // --------------------------------------------------------------------------
  // register side
  // --------------------------------------------------------------------------

  // control register, bit 0 goes to led_0
  output led_board_pkg::data_t       led_ctrl,
  // live blinker count for the status register
  input  wire  led_board_pkg::data_t blink_count
);

  import led_board_pkg::*;

  wr_state_t wr_state;
  rd_state_t rd_state;

  // handshake strobes, one cycle each
  logic      wr_hs;
  logic      rd_hs;

  // write decode
  logic      wr_hit_ctrl;
  axi_resp_t wr_resp_next;

  // read decode
  data_t     rd_data_next;
  axi_resp_t rd_resp_next;

  // --------------------------------------------------------------------------
  // write channel
  // --------------------------------------------------------------------------

  // aw and w taken together, only when no response is pending
  assign wr_hs   = (wr_state == WR_IDLE) && awvalid && wvalid;
  assign awready = wr_hs;
  assign wready  = wr_hs;

  // response valid for as long as the fsm sits in WR_RESP
  assign bvalid  = (wr_state == WR_RESP);

  // only the control register is writable
  assign wr_hit_ctrl  = (awaddr == REG_LED_CTRL);
  assign wr_resp_next = wr_hit_ctrl ? RESP_OKAY : RESP_SLVERR;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (wr_hs) begin
            wr_state <= WR_RESP;
          end
        end
        WR_RESP: begin
          // back-pressure, stay until the master takes it
          if (bready) begin
            wr_state <= WR_IDLE;
          end
        end
        default: begin
          wr_state <= WR_IDLE;
        end
      endcase
    end
  end

  // response code captured at the handshake, stable while bvalid
  always_ff @(posedge clk) begin
    if (wr_hs) begin
      bresp <= wr_resp_next;
    end
  end

  // control register with byte strobes
  // lands in the same edge that raises bvalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led_ctrl <= '0;
    end else if (wr_hs && wr_hit_ctrl) begin
      for (int i = 0; i < strb_width; i++) begin
        if (wstrb[i]) begin
          led_ctrl[8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // read channel
  // --------------------------------------------------------------------------

  // no new address while read data is still pending
  assign rd_hs   = (rd_state == RD_IDLE) && arvalid;
  assign arready = rd_hs;
  assign rvalid  = (rd_state == RD_DATA);

  // read mux
  always_comb begin
    case (reg_addr_t'(araddr))
      REG_LED_CTRL: begin
        rd_data_next = led_ctrl;
        rd_resp_next = RESP_OKAY;
      end
      REG_BLINK_COUNT: begin
        // snapshot of the counter at the address handshake
        rd_data_next = blink_count;
        rd_resp_next = RESP_OKAY;
      end
      default: begin
        // unmapped, zero data
        rd_data_next = '0;
        rd_resp_next = RESP_SLVERR;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (rd_hs) begin
            rd_state <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (rready) begin
            rd_state <= RD_IDLE;
          end
        end
        default: begin
          rd_state <= RD_IDLE;
        end
      endcase
    end
  end

  // data and response held until rready
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rdata <= rd_data_next;
      rresp <= rd_resp_next;
    end
  end

endmodule

`default_nettype wire

// File: button_led_toggle.sv
// one push button in, one led out; synchronize, debounce, toggle on each press
`default_nettype none

module button_led_toggle #(
  // stable cycles before the debounced level follows the input
  parameter int debounce_cycles = led_board_pkg::default_debounce_cycles
) (
  input  wire  clk,
  input  wire  rst_n,
  // raw, asynchronous to clk
  input  wire  btn,
  output logic led
);

  import led_board_pkg::*;

  // two flop synchronizer
  logic  btn_meta;
  logic  btn_sync;

  // debounce state
  data_t db_count;
  logic  db_level;
  // previous debounced level for edge detect
  logic  db_level_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      btn_meta <= 1'b0;
      btn_sync <= 1'b0;
    end else begin
      btn_meta <= btn;
      btn_sync <= btn_meta;
    end
  end

  // --------------------------------------------------------------------------
  // debounce
  // --------------------------------------------------------------------------

  // count cycles the synced input differs from the debounced level
  // any agreement restarts the count, so short glitches die here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      db_count <= '0;
      db_level <= 1'b0;
    end else if (btn_sync == db_level) begin
      db_count <= '0;
    end else if (db_count == data_t'(debounce_cycles - 1)) begin
      db_count <= '0;
      db_level <= btn_sync;
    end else begin
      db_count <= db_count + data_t'(1);
    end
  end

  // toggle one cycle after the debounced level rises
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      db_level_q <= 1'b0;
      led        <= 1'b0;
    end else begin
      db_level_q <= db_level;
      if (db_level && !db_level_q) begin
        led <= ~led;
      end
    end
  end

endmodule

`default_nettype wire

// File: led_blinker.sv
// free-running blinker for led_3; the count is also exposed as a status value
`default_nettype none

module led_blinker #(
  // cycles between led edges
  parameter int half_period = led_board_pkg::default_blink_half_period
) (
  input  wire                  clk,
  input  wire                  rst_n,
  // 0 .. half_period-1
  output led_board_pkg::data_t count,
  output logic                 led
);

  import led_board_pkg::*;

  // last count before the wrap
  logic wrap;

  assign wrap = (count == data_t'(half_period - 1));

  // wrapping counter, led flips in the wrap cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
      led   <= 1'b0;
    end else if (wrap) begin
      count <= '0;
      led   <= ~led;
    end else begin
      count <= count + data_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: led_board_top.sv
// board control top: axi4-lite registers, two button toggles and the blinker driving four leds
`default_nettype none

module led_board_top #(
  parameter int blink_half_period = led_board_pkg::default_blink_half_period,
  parameter int debounce_cycles   = led_board_pkg::default_debounce_cycles
) (
  input  wire                        clk,
  input  wire                        rst_n,

  // board i/o
  input  wire                        btn_1,
  input  wire                        btn_2,
  output logic                       led_0,
  output logic                       led_1,
  output logic                       led_2,
  output logic                       led_3,

  // --------------------------------------------------------------------------
  // axi4-lite register port
  // --------------------------------------------------------------------------

  input  wire  led_board_pkg::addr_t awaddr,
  input  wire                        awvalid,
  output logic                       awready,
  input  wire  led_board_pkg::data_t wdata,
  input  wire  led_board_pkg::strb_t wstrb,
  input  wire                        wvalid,
  output logic                       wready,
  output led_board_pkg::axi_resp_t   bresp,
  output logic                       bvalid,
  input  wire                        bready,
  input  wire  led_board_pkg::addr_t araddr,
  input  wire                        arvalid,
  output logic                       arready,
  output led_board_pkg::data_t       rdata,
  output led_board_pkg::axi_resp_t   rresp,
  output logic                       rvalid,
  input  wire                        rready
);

  import led_board_pkg::*;

  // control register from the slave
  data_t led_ctrl;
  // blinker count into the status register
  data_t blink_count;

  // software led, straight off the register
  assign led_0 = led_ctrl[0];

  // --------------------------------------------------------------------------
  // register slave
  // --------------------------------------------------------------------------

  axi_lite_regs i_regs (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .awaddr      ( awaddr      ),
    .awvalid     ( awvalid     ),
    .awready     ( awready     ),
    .wdata       ( wdata       ),
    .wstrb       ( wstrb       ),
    .wvalid      ( wvalid      ),
    .wready      ( wready      ),
    .bresp       ( bresp       ),
    .bvalid      ( bvalid      ),
    .bready      ( bready      ),
    .araddr      ( araddr      ),
    .arvalid     ( arvalid     ),
    .arready     ( arready     ),
    .rdata       ( rdata       ),
    .rresp       ( rresp       ),
    .rvalid      ( rvalid      ),
    .rready      ( rready      ),
    .led_ctrl    ( led_ctrl    ),
    .blink_count ( blink_count )
  );

  // --------------------------------------------------------------------------
  // buttons, each owns its led
  // --------------------------------------------------------------------------

  button_led_toggle #(
    .debounce_cycles ( debounce_cycles )
  ) i_btn_1 (
    .clk   ( clk   ),
    .rst_n ( rst_n ),
    .btn   ( btn_1 ),
    .led   ( led_1 )
  );

  button_led_toggle #(
    .debounce_cycles ( debounce_cycles )
  ) i_btn_2 (
    .clk   ( clk   ),
    .rst_n ( rst_n ),
    .btn   ( btn_2 ),
    .led   ( led_2 )
  );

  // heartbeat on led_3
  led_blinker #(
    .half_period ( blink_half_period )
  ) i_blinker (
    .clk   ( clk         ),
    .rst_n ( rst_n       ),
    .count ( blink_count ),
    .led   ( led_3       )
  );

endmodule

`default_nettype wire

// File: led_board_assertions.sv
// concurrent handshake and reset checks for the led board top; bound into every led_board_top
`default_nettype none

module led_board_assertions (
  input wire                           clk,
  input wire                           rst_n,
  input wire                           awready,
  input wire                           wready,
  input wire                           bvalid,
  input wire                           bready,
  input wire led_board_pkg::axi_resp_t bresp,
  input wire                           arready,
  input wire                           rvalid,
  input wire                           rready,
  input wire led_board_pkg::data_t     rdata,
  input wire led_board_pkg::axi_resp_t rresp,
  input wire                           led_0,
  input wire                           led_1,
  input wire                           led_2,
  input wire                           led_3
);
  timeunit 1ns;
  timeprecision 1ps;

  // aw and w are always taken in the same cycle
  aw_w_paired: assert property (@(posedge clk) disable iff (!rst_n) awready == wready)
    else $error("awready and wready differ");

  // stalled write response stays put
  b_held: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("write response dropped or changed before bready");

  // stalled read data stays put
  r_held: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("read data dropped or changed before rready");

  // one outstanding read at most
  ar_blocked: assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> !arready)
    else $error("read address accepted while read data pending");

  // all leds dark right out of reset
  leds_dark: assert property (@(posedge clk) $rose(rst_n) |-> !led_0 && !led_1 && !led_2 && !led_3)
    else $error("an led is lit in the first cycle after reset");

endmodule

bind led_board_top led_board_assertions i_led_board_assertions (.*);

`default_nettype wire

// File: tb_led_board.sv
// testbench for the led board top; runs the operations in led_board_vectors.txt and checks each result
`default_nettype none

module tb_led_board;
  timeunit 1ns;
  timeprecision 1ps;

  import led_board_pkg::*;

  // small timing so the whole run stays short
  localparam int blink_half_period = 16;
  localparam int debounce_cycles   = 8;
  // handshake and edge waits give up after this
  localparam int hs_timeout        = 50;
  // watchdog budget
  localparam int cycles_per_line   = 40;
  localparam int extra_cycles      = 200;

  logic      clk;
  logic      rst_n;
  logic      btn_1;
  logic      btn_2;
  logic      led_0;
  logic      led_1;
  logic      led_2;
  logic      led_3;
  addr_t     awaddr;
  logic      awvalid;
  logic      awready;
  data_t     wdata;
  strb_t     wstrb;
  logic      wvalid;
  logic      wready;
  axi_resp_t bresp;
  logic      bvalid;
  logic      bready;
  addr_t     araddr;
  logic      arvalid;
  logic      arready;
  data_t     rdata;
  axi_resp_t rresp;
  logic      rvalid;
  logic      rready;

  // one entry per vector line
  string      vec_name [$];
  string      vec_op [$];
  data_t      vec_a0 [$];
  data_t      vec_a1 [$];
  data_t      vec_a2 [$];
  data_t      vec_exp [$];
  logic [1:0] vec_resp [$];

  string  test_name;
  int     test_errors;
  int     pass_count  = 0;
  int     fail_count  = 0;
  int     cycle_count = 0;
  int     cycle_limit = extra_cycles;
  integer seed        = 32'h96e6_a4c9;

  led_board_top #(
    .blink_half_period ( blink_half_period ),
    .debounce_cycles   ( debounce_cycles   )
  ) i_led_board_top (.*);

  always #4 clk = ~clk;

  // watchdog, limit set once the vectors are loaded
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("run stopped: still busy after %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------

  task automatic check_resp(input string what, input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  // upper bound only, for live counter values
  task automatic check_below(input string what, input data_t bound, input data_t act);
    if (!(act < bound)) begin
      $display("CHECK FAILED %s %s expected below %h actual %h", test_name, what, bound, act);
      test_errors++;
    end
  endtask

  task automatic check_led(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s expected %b actual %b", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("test %s: %s", test_name, what);
    test_errors++;
  endtask

  // --------------------------------------------------------------------------
  // vector file
  // --------------------------------------------------------------------------

  task automatic load_vectors();
    int         fd;
    int         code;
    string      name;
    string      op;
    string      rest;
    data_t      a0;
    data_t      a1;
    data_t      a2;
    data_t      ed;
    logic [1:0] er;
    fd = $fopen("led_board_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open led_board_vectors.txt");
      fail_count++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", name);
        if (code == 1 && name == "#") begin
          // rest of a comment line
          code = $fgets(rest, fd);
        end else if (code == 1) begin
          code = $fscanf(fd, "%s %h %h %h %h %h", op, a0, a1, a2, ed, er);
          if (code == 6) begin
            vec_name.push_back(name);
            vec_op.push_back(op);
            vec_a0.push_back(a0);
            vec_a1.push_back(a1);
            vec_a2.push_back(a2);
            vec_exp.push_back(ed);
            vec_resp.push_back(er);
          end else begin
            $display("vector line %s is incomplete", name);
            fail_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // --------------------------------------------------------------------------
  // bus tasks, inputs change on the falling edge
  // --------------------------------------------------------------------------

  task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                           input data_t exp_ctrl, input axi_resp_t exp_resp);
    int waited;
    waited  = 0;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    while (!(awready && wready) && waited < hs_timeout) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (!(awready && wready)) begin
      report_problem("write address and data were never accepted");
      awvalid = 1'b0;
      wvalid  = 1'b0;
    end else begin
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      if (!bvalid) begin
        report_problem("bvalid did not rise one cycle after the write handshake");
      end else begin
        check_resp("bresp", exp_resp, bresp);
        // control register lands with bvalid
        check_led("led_0", exp_ctrl[0], led_0);
        // bready off one more cycle, response must hold
        @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
      end
    end
  endtask

  task automatic axi_read(input addr_t addr, input logic below, input data_t exp_data,
                          input axi_resp_t exp_resp);
    int     waited;
    int     hold;
    integer rnd;
    waited  = 0;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    while (!arready && waited < hs_timeout) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (!arready) begin
      report_problem("read address was never accepted");
      arvalid = 1'b0;
    end else begin
      @(negedge clk);
      arvalid = 1'b0;
      if (!rvalid) begin
        report_problem("rvalid did not rise one cycle after the read handshake");
      end else begin
        // stall 0..3 cycles, data must hold meanwhile
        rnd  = $random(seed);
        hold = rnd & 3;
        repeat (hold) @(negedge clk);
        check_resp("rresp", exp_resp, rresp);
        if (below) begin
          check_below("rdata", exp_data, rdata);
        end else begin
          check_data("rdata", exp_data, rdata);
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // buttons and blinker
  // --------------------------------------------------------------------------

  // high for high_cycles, low for low_cycles, then both leds compared
  task automatic pulse_button(input data_t which, input data_t high_cycles,
                              input data_t low_cycles, input data_t exp_leds);
    @(negedge clk);
    if (which == 1) begin
      btn_1 = 1'b1;
    end else begin
      btn_2 = 1'b1;
    end
    repeat (high_cycles) @(negedge clk);
    btn_1 = 1'b0;
    btn_2 = 1'b0;
    repeat (low_cycles) @(negedge clk);
    check_led("led_1", exp_leds[0], led_1);
    check_led("led_2", exp_leds[1], led_2);
  endtask

  // counts falling edges until led_3 changes
  task automatic count_to_led3_edge(output int cycles, output logic seen);
    logic prev;
    prev   = led_3;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < hs_timeout) begin
      @(negedge clk);
      cycles++;
      seen = (led_3 != prev);
    end
  endtask

  task automatic measure_blink(input data_t gaps, input data_t exp_gap);
    int   cycles;
    logic seen;
    // first edge only aligns the measurement
    count_to_led3_edge(cycles, seen);
    for (int n = 0; n < gaps && seen; n++) begin
      count_to_led3_edge(cycles, seen);
      if (seen) begin
        check_data("led_3 gap", exp_gap, data_t'(cycles));
      end
    end
    if (!seen) begin
      report_problem("led_3 stopped toggling");
    end
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      pass_count++;
      $display("test %s: ok", test_name);
    end else begin
      fail_count++;
      $display("test %s: failed with %0d errors", test_name, test_errors);
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    btn_1   = 1'b0;
    btn_2   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    load_vectors();
    cycle_limit = cycles_per_line * vec_op.size() + extra_cycles;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    test_name   = "reset_leds";
    test_errors = 0;
    check_led("led_0", 1'b0, led_0);
    check_led("led_1", 1'b0, led_1);
    check_led("led_2", 1'b0, led_2);
    check_led("led_3", 1'b0, led_3);
    finish_test();

    for (int i = 0; i < vec_op.size(); i++) begin
      test_name   = vec_name[i];
      test_errors = 0;
      if (vec_op[i] == "write") begin
        axi_write(addr_t'(vec_a0[i]), vec_a1[i], strb_t'(vec_a2[i]), vec_exp[i],
                  axi_resp_t'(vec_resp[i]));
      end else if (vec_op[i] == "read") begin
        axi_read(addr_t'(vec_a0[i]), vec_a1[i][0], vec_exp[i], axi_resp_t'(vec_resp[i]));
      end else if (vec_op[i] == "press" || vec_op[i] == "glitch") begin
        pulse_button(vec_a0[i], vec_a1[i], vec_a2[i], vec_exp[i]);
      end else if (vec_op[i] == "blink") begin
        measure_blink(vec_a0[i], vec_exp[i]);
      end else begin
        report_problem({"unknown operation ", vec_op[i]});
      end
      finish_test();
    end

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: led_board_vectors.txt
# columns: name op arg0 arg1 arg2 exp_data exp_resp, numbers in hex
# write: addr wdata wstrb, exp_data = control register after the write
# read: addr, arg1 = 1 means rdata must be below exp_data, else equal
# press / glitch: button high_cycles low_cycles, exp_data = {led_2, led_1}
# blink: gaps to measure, exp_data = cycles between led_3 edges
rst_read_ctrl     read    00 0        0  00000000 0
wr_all_bytes      write   00 a5a5a5a5 f  a5a5a5a5 0
rd_all_bytes      read    00 0        0  a5a5a5a5 0
wr_byte0          write   00 12345678 1  a5a5a578 0
rd_byte0          read    00 0        0  a5a5a578 0
wr_byte3          write   00 ff000001 8  ffa5a578 0
wr_bytes12        write   00 00c3d200 6  ffc3d278 0
rd_bytes123       read    00 0        0  ffc3d278 0
wr_led0_on        write   00 00000001 1  ffc3d201 0
rd_led0_on        read    00 0        0  ffc3d201 0
wr_blink_count    write   04 00000000 f  ffc3d201 2
wr_unmapped       write   40 00000000 f  ffc3d201 2
wr_unmapped_08    write   08 0000ffff 3  ffc3d201 2
rd_after_errors   read    00 0        0  ffc3d201 0
rd_unmapped       read    40 0        0  00000000 2
rd_blink_count    read    04 1        0  00000010 0
press_btn1        press   1  14       14 00000001 0
press_btn2        press   2  14       14 00000003 0
press_btn1_again  press   1  14       14 00000002 0
glitch_btn2       glitch  2  4        14 00000002 0
glitch_btn1       glitch  1  4        14 00000002 0
press_btn2_again  press   2  14       14 00000000 0
blink_gaps        blink   3  0        0  00000010 0
wr_clear          write   00 00000000 f  00000000 0
rd_clear          read    00 0        0  00000000 0

// File: compile.f
led_board_pkg.sv
axi_lite_regs.sv
button_led_toggle.sv
led_blinker.sv
led_board_top.sv
led_board_assertions.sv
tb_led_board.sv

// File: run_sim.sh
#!/bin/sh
# build the led board testbench with verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module tb_led_board -Mdir obj_dir -o tb_led_board_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_led_board_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> FAIL$' "$log"; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q '^>>> PASS$' "$log"; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0
